// ==== verif/opll_regs_input.txt ====
# W a0 data : one bus write in hex, a0 0 for an address, 1 for data
# E ch car fnum block key sus instr vol am vib eg ksr multi ksl tl wf fb ar dr sl rr (hex)
# channel banks on channel 3, then 0x19 which is ignored
W 0 13
W 1 5a
W 0 23
W 1 3b
W 0 33
W 1 07
W 0 19
W 1 ff
E 3 0 15a 5 1 1 0 7 0 0 0 0 0 0 00 0 0 0 0 0 0
E 3 1 15a 5 1 1 0 7 0 0 0 0 0 0 00 0 0 0 0 0 0
E 1 1 000 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0
E 4 0 000 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 0 0 0
# custom instrument 0x00 to 0x07
W 0 00
W 1 a3
W 0 01
W 1 5c
W 0 02
W 1 9e
W 0 03
W 1 55
W 0 04
W 1 f2
W 0 05
W 1 7a
W 0 06
W 1 38
W 0 07
W 1 c6
E 0 0 000 0 0 0 0 0 1 0 1 0 3 2 1e 0 5 f 2 3 8
E 0 1 000 0 0 0 0 0 0 1 0 1 c 1 00 1 0 7 a c 6
E 3 0 15a 5 1 1 0 7 1 0 1 0 3 2 1e 0 5 f 2 3 8
E 8 1 000 0 0 0 0 0 0 1 0 1 c 1 00 1 0 7 a c 6
# ROM instruments 1 and 11
W 0 31
W 1 14
W 0 34
W 1 b0
E 1 0 000 0 0 0 1 4 0 1 1 1 1 0 1e 0 7 d 0 0 0
E 1 1 000 0 0 0 1 4 0 1 1 0 1 0 00 1 0 7 8 1 7
E 4 0 000 0 0 0 b 0 0 0 1 1 3 2 03 0 1 e a 1 0
E 4 1 000 0 0 0 b 0 0 0 0 0 1 0 00 1 0 e f 0 4
# rhythm mode with bd and tc set, key on channel 7
W 0 36
W 1 25
W 0 27
W 1 10
W 0 0e
W 1 32
E 6 0 000 0 1 0 2 5 0 0 0 0 1 0 18 1 7 d f 6 a
E 6 1 000 0 1 0 2 5 0 0 0 0 1 0 00 0 0 f 8 6 d
E 7 0 000 0 1 0 0 0 0 0 0 0 1 0 00 0 0 c 8 a 7
E 7 1 000 0 1 0 0 0 0 0 0 0 1 0 00 0 0 d 8 6 8
E 8 0 000 0 0 0 0 0 0 0 0 0 5 0 00 0 0 f 8 5 9
E 8 1 000 0 1 0 0 0 0 0 0 0 1 0 00 0 0 a a 5 5
E 0 0 000 0 0 0 0 0 1 0 1 0 3 2 1e 0 5 f 2 3 8
E 4 1 000 0 0 0 b 0 0 0 0 0 1 0 00 1 0 e f 0 4

// ==== sim.f ====
common/opll_pkg.sv
logic/bus_decoder.sv
regs/channel_regs.sv
regs/patch_regs.sv
slot/patch_rom.sv
slot/slot_assembler.sv
logic/opll_regs_top.sv
verif/opll_regs_sva.sv
verif/tb_opll_regs.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := tb_opll_regs
FILELIST := sim.f
OBJ_DIR := obj_dir
SIM_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_opll_regs.sv ====
`default_nettype none

module tb_opll_regs;

	localparam int reset_cycles = 3;

	logic MCLK;
	logic rst_n;
	logic cs;
	logic we;
	logic a0;
	logic [7:0] data;
	opll_pkg::slot_params_t slot;

	// one frame of records, indexed by slot
	opll_pkg::slot_params_t frame [opll_pkg::num_slots];
	string lines [$];
	int seed = 78;
	int cycle_count = 0;
	int limit_cycles = 0;

	opll_regs_top i_opll_regs_top
	(
		.MCLK(MCLK),
		.rst_n(rst_n),
		.cs(cs),
		.we(we),
		.a0(a0),
		.data(data),
		.slot(slot)
	);

	initial
	begin
		MCLK = 1'b0;
		forever
			#20 MCLK = ~MCLK;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	always @(posedge MCLK)
	begin
		cycle_count = cycle_count + 1;
		if (cycle_count > limit_cycles)
			fail_run($sformatf("simulation timed out after %0d cycles", cycle_count));
	end

	task automatic check_state(input opll_pkg::channel_state_t got,
		input opll_pkg::channel_state_t exp, input int ch, input logic car);
		if (got !== exp)
			fail_run($sformatf("FAILED at %0t: ch %0d car %0d channel state %h, expected %h",
				$time, ch, car, got, exp));
	endtask

	task automatic check_patch(input opll_pkg::op_patch_t got,
		input opll_pkg::op_patch_t exp, input int ch, input logic car);
		if (got !== exp)
			fail_run($sformatf("FAILED at %0t: ch %0d car %0d operator patch %h, expected %h",
				$time, ch, car, got, exp));
	endtask

	task automatic bus_write(input logic sel_a0, input logic [7:0] value);
		@(negedge MCLK);
		cs = 1'b1;
		we = 1'b1;
		a0 = sel_a0;
		data = value;
		@(negedge MCLK);
		cs = 1'b0;
		we = 1'b0;
	endtask

	task automatic collect_frame();
		bit seen [opll_pkg::num_slots];
		int idx;
		foreach (seen[i])
			seen[i] = 1'b0;
		// two cycles for a write to reach the records
		@(negedge MCLK);
		for (int n = 0; n < opll_pkg::num_slots; n++)
		begin
			@(negedge MCLK);
			if (slot.valid !== 1'b1)
				fail_run("a slot record was not valid after reset release");
			if (slot.channel >= 4'(opll_pkg::num_channels))
				fail_run($sformatf("a slot record has channel %0d, outside 0 to 8",
					slot.channel));
			idx = 2 * int'(slot.channel) + int'(slot.is_car);
			if (seen[idx])
				fail_run($sformatf("slot %0d appeared twice in one frame", idx));
			seen[idx] = 1'b1;
			frame[idx] = slot;
		end
	endtask

	task automatic run_expect(input string line);
		int f [21];
		int n;
		int idx;
		opll_pkg::channel_state_t exp_state;
		opll_pkg::op_patch_t exp_patch;
		n = $sscanf(line, "E %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
			f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
			f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]);
		if (n != 21 || f[0] >= opll_pkg::num_channels || f[1] > 1)
			fail_run({"the data file has a malformed expect line: ", line});
		exp_state.fnum = 9'(f[2]);
		exp_state.block = 3'(f[3]);
		exp_state.key_on = 1'(f[4]);
		exp_state.sus_on = 1'(f[5]);
		exp_state.instrument = 4'(f[6]);
		exp_state.volume = 4'(f[7]);
		exp_patch.am = 1'(f[8]);
		exp_patch.vib = 1'(f[9]);
		exp_patch.eg_type = 1'(f[10]);
		exp_patch.ksr = 1'(f[11]);
		exp_patch.multi = 4'(f[12]);
		exp_patch.ksl = 2'(f[13]);
		exp_patch.tl = 6'(f[14]);
		exp_patch.wf = 1'(f[15]);
		exp_patch.feedback = 3'(f[16]);
		exp_patch.ar = 4'(f[17]);
		exp_patch.dr = 4'(f[18]);
		exp_patch.sl = 4'(f[19]);
		exp_patch.rr = 4'(f[20]);
		idx = 2 * f[0] + f[1];
		check_state(frame[idx].ch_state, exp_state, f[0], f[1] != 0);
		check_patch(frame[idx].patch, exp_patch, f[0], f[1] != 0);
	endtask

	// one address write, then random data writes to fnum low of channel 5
	task automatic check_last_write_wins();
		logic [7:0] last;
		int count;
		opll_pkg::channel_state_t exp;
		count = 4 + int'($unsigned($random(seed)) % 4);
		last = '0;
		bus_write(1'b0, opll_pkg::addr_fnum_lo | 8'h05);
		for (int i = 0; i < count; i++)
		begin
			last = 8'($random(seed));
			bus_write(1'b1, last);
		end
		collect_frame();
		exp = '0;
		exp.fnum[7:0] = last;
		check_state(frame[10].ch_state, exp, 5, 1'b0);
		check_state(frame[11].ch_state, exp, 5, 1'b1);
	endtask

	initial
	begin
		int fd;
		int code;
		int wa0;
		int wdata;
		byte cmd;
		bit fresh;
		string line;
		rst_n = 1'b0;
		cs = 1'b0;
		we = 1'b0;
		a0 = 1'b0;
		data = '0;
		fd = $fopen("verif/opll_regs_input.txt", "r");
		if (fd == 0)
			fail_run("cannot open the stimulus file verif/opll_regs_input.txt");
		while (!$feof(fd))
		begin
			code = $fgets(line, fd);
			if (code > 0)
				lines.push_back(line);
		end
		$fclose(fd);
		limit_cycles = 30 * lines.size() + reset_cycles;

		repeat (reset_cycles) @(negedge MCLK);
		rst_n = 1'b1;

		// all zero after reset
		collect_frame();
		foreach (frame[i])
		begin
			check_state(frame[i].ch_state, '0, i / 2, (i % 2) != 0);
			check_patch(frame[i].patch, '0, i / 2, (i % 2) != 0);
		end
		fresh = 1'b1;

		foreach (lines[k])
		begin
			cmd = (lines[k].len() > 0) ? lines[k].getc(0) : 8'h20;
			if (cmd == "W")
			begin
				if ($sscanf(lines[k], "W %h %h", wa0, wdata) != 2)
					fail_run({"the data file has a malformed write line: ", lines[k]});
				bus_write(wa0 != 0, 8'(wdata));
				fresh = 1'b0;
			end
			else if (cmd == "E")
			begin
				if (!fresh)
				begin
					collect_frame();
					fresh = 1'b1;
				end
				run_expect(lines[k]);
			end
		end

		check_last_write_wins();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/opll_regs_sva.sv ====
`default_nettype none

module opll_regs_sva
(
	input wire logic MCLK,
	input wire logic rst_n,
	input wire logic [4:0] slot_cnt,
	input wire opll_pkg::slot_params_t slot
);

	// stream never pauses once started
	valid_held: assert property (@(posedge MCLK) disable iff (!rst_n)
		slot.valid |=> slot.valid)
		else $error("slot valid dropped after it had risen");

	cnt_step: assert property (@(posedge MCLK) disable iff (!rst_n)
		slot_cnt < 5'(opll_pkg::num_slots - 1) |=> slot_cnt == $past(slot_cnt) + 5'd1)
		else $error("slot index did not step by one");

	cnt_wrap: assert property (@(posedge MCLK) disable iff (!rst_n)
		slot_cnt == 5'(opll_pkg::num_slots - 1) |=> slot_cnt == 5'd0)
		else $error("slot index did not wrap from 17 to 0");

	// record built from the previous index
	car_bit: assert property (@(posedge MCLK) disable iff (!rst_n)
		slot.valid |-> slot.is_car == $past(slot_cnt[0]))
		else $error("is_car does not match the slot index");

endmodule

bind slot_assembler opll_regs_sva i_opll_regs_sva
(
	.MCLK(MCLK),
	.rst_n(rst_n),
	.slot_cnt(slot_cnt),
	.slot(slot)
);

`default_nettype wire

// ==== logic/opll_regs_top.sv ====
`default_nettype none

module opll_regs_top
(
	input wire logic MCLK,
	input wire logic rst_n,
	input wire logic cs,
	input wire logic we,
	input wire logic a0,
	input wire logic [7:0] data,
	output opll_pkg::slot_params_t slot
);

	opll_pkg::host_write_t wr;
	opll_pkg::channel_state_t ch_state;
	opll_pkg::custom_patch_t custom;
	opll_pkg::rhythm_t rhythm;
	logic [3:0] ch_sel;

	bus_decoder i_bus_decoder
	(
		.MCLK(MCLK),
		.rst_n(rst_n),
		.cs(cs),
		.we(we),
		.a0(a0),
		.data(data),
		.wr(wr)
	);

	channel_regs i_channel_regs
	(
		.MCLK(MCLK),
		.rst_n(rst_n),
		.wr(wr),
		.ch_sel(ch_sel),
		.ch_state(ch_state)
	);

	patch_regs i_patch_regs
	(
		.MCLK(MCLK),
		.rst_n(rst_n),
		.wr(wr),
		.custom(custom),
		.rhythm(rhythm)
	);

	slot_assembler i_slot_assembler
	(
		.MCLK(MCLK),
		.rst_n(rst_n),
		.ch_state(ch_state),
		.custom(custom),
		.rhythm(rhythm),
		.ch_sel(ch_sel),
		.slot(slot)
	);

endmodule

`default_nettype wire

// ==== slot/slot_assembler.sv ====
`default_nettype none

module slot_assembler
(
	input wire logic MCLK,
	input wire logic rst_n,
	input wire opll_pkg::channel_state_t ch_state,
	input wire opll_pkg::custom_patch_t custom,
	input wire opll_pkg::rhythm_t rhythm,
	output logic [3:0] ch_sel,
	output opll_pkg::slot_params_t slot
);

	logic [4:0] slot_cnt;
	logic is_car;
	logic [1:0] rhythm_sel;
	logic rhythm_key;
	opll_pkg::op_patch_t rom_patch;
	opll_pkg::op_patch_t patch;
	opll_pkg::channel_state_t merged;

	// slot index is 2 * channel + is_car
	assign ch_sel = slot_cnt[4:1];
	assign is_car = slot_cnt[0];

	// 1, 2, 3 for channels 6, 7, 8 in rhythm mode
	always_comb
	begin
		rhythm_sel = 2'd0;
		if (rhythm.enable && ch_sel >= 4'(opll_pkg::rhythm_first_ch))
			rhythm_sel = 2'(ch_sel - 4'(opll_pkg::rhythm_first_ch) + 4'd1);
	end

	patch_rom i_patch_rom
	(
		.instr(ch_state.instrument),
		.is_car(is_car),
		.rhythm_sel(rhythm_sel),
		.rom_patch(rom_patch)
	);

	always_comb
	begin
		case (rhythm_sel)
			2'd1: rhythm_key = rhythm.bd;
			2'd2: rhythm_key = is_car ? rhythm.sd : rhythm.hh;
			2'd3: rhythm_key = is_car ? rhythm.tc : rhythm.tom;
			default: rhythm_key = 1'b0;
		endcase
	end

	always_comb
	begin
		merged = ch_state;
		merged.key_on = ch_state.key_on | rhythm_key;
	end

	assign patch = (rhythm_sel != 2'd0 || ch_state.instrument != 4'd0) ? rom_patch
		: (is_car ? custom.carrier : custom.modulator);

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			slot_cnt <= '0;
			slot <= '0;
		end
		else
		begin
			slot_cnt <= (slot_cnt == 5'(opll_pkg::num_slots - 1)) ? 5'd0 : slot_cnt + 5'd1;
			slot.valid <= 1'b1;
			slot.channel <= ch_sel;
			slot.is_car <= is_car;
			slot.ch_state <= merged;
			slot.patch <= patch;
		end
	end

endmodule

`default_nettype wire

// ==== slot/patch_rom.sv ====
`default_nettype none

module patch_rom
(
	input wire logic [3:0] instr,
	input wire logic is_car,
	input wire logic [1:0] rhythm_sel,
	output opll_pkg::op_patch_t rom_patch
);

	// one row holds registers 0x00 to 0x07 of an instrument
	logic [63:0] row;

	always_comb
	begin
		case (rhythm_sel)
			// bd on both operators
			2'd1: row = 64'h01_01_18_0f_df_f8_6a_6d;
			// hh modulator, sd carrier
			2'd2: row = 64'h01_01_00_00_c8_d8_a7_68;
			// tom modulator, tc carrier
			2'd3: row = 64'h05_01_00_00_f8_aa_59_55;
			default:
			begin
				case (instr)
					4'h1: row = 64'h71_61_1e_17_d0_78_00_17;
					4'h2: row = 64'h13_41_1a_0d_d8_f7_23_13;
					4'h3: row = 64'h13_01_99_00_f2_c4_21_23;
					4'h4: row = 64'h11_61_0e_07_8d_64_70_27;
					4'h5: row = 64'h32_21_1e_06_e1_76_01_28;
					4'h6: row = 64'h31_22_16_05_e0_71_00_18;
					4'h7: row = 64'h21_61_1d_07_82_81_11_07;
					4'h8: row = 64'h33_21_2d_13_b0_70_00_07;
					4'h9: row = 64'h61_61_1b_06_64_65_10_17;
					4'ha: row = 64'h41_61_0b_18_85_f0_81_07;
					4'hb: row = 64'h33_01_83_11_ea_ef_10_04;
					4'hc: row = 64'h17_c1_24_07_f8_f8_22_12;
					4'hd: row = 64'h61_50_0c_05_d2_f5_40_16;
					4'he: row = 64'h01_01_55_03_e9_90_03_02;
					4'hf: row = 64'h41_41_89_03_f1_e4_c0_13;
					// instrument 0 is the custom patch, not stored here
					default: row = '0;
				endcase
			end
		endcase
	end

	assign rom_patch = opll_pkg::unpack_op(row, is_car);

endmodule

`default_nettype wire

// ==== regs/patch_regs.sv ====
`default_nettype none

module patch_regs
(
	input wire logic MCLK,
	input wire logic rst_n,
	input wire opll_pkg::host_write_t wr,
	output opll_pkg::custom_patch_t custom,
	output opll_pkg::rhythm_t rhythm
);

	logic [7:0] custom_q [8];
	logic [5:0] rhythm_q;
	logic [63:0] custom_bytes;

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int k = 0; k < 8; k++)
				custom_q[k] <= '0;
			rhythm_q <= '0;
		end
		else if (wr.valid)
		begin
			// 0x00 to 0x07
			if (wr.addr[7:3] == 5'd0)
				custom_q[wr.addr[2:0]] <= wr.data;
			else if (wr.addr == opll_pkg::addr_rhythm)
				rhythm_q <= wr.data[5:0];
		end
	end

	assign custom_bytes = {
		custom_q[0], custom_q[1], custom_q[2], custom_q[3],
		custom_q[4], custom_q[5], custom_q[6], custom_q[7]
	};

	assign custom = '{
		modulator: opll_pkg::unpack_op(custom_bytes, 1'b0),
		carrier: opll_pkg::unpack_op(custom_bytes, 1'b1)
	};

	assign rhythm = opll_pkg::rhythm_t'(rhythm_q);

endmodule

`default_nettype wire

// ==== regs/channel_regs.sv ====
`default_nettype none

module channel_regs
(
	input wire logic MCLK,
	input wire logic rst_n,
	input wire opll_pkg::host_write_t wr,
	input wire logic [3:0] ch_sel,
	output opll_pkg::channel_state_t ch_state
);

	opll_pkg::channel_state_t state_q [opll_pkg::num_channels];
	logic [3:0] wr_ch;
	logic ch_hit;

	assign wr_ch = wr.addr[3:0];
	// low nibbles 9 to 15 fall outside the channel range
	assign ch_hit = wr.valid && (wr_ch < 4'(opll_pkg::num_channels));

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < opll_pkg::num_channels; i++)
				state_q[i] <= '0;
		end
		else if (ch_hit)
		begin
			case (wr.addr[7:4])
				opll_pkg::addr_fnum_lo[7:4]:
					state_q[wr_ch].fnum[7:0] <= wr.data;
				opll_pkg::addr_fnum_hi[7:4]:
				begin
					state_q[wr_ch].fnum[8] <= wr.data[0];
					state_q[wr_ch].block <= wr.data[3:1];
					state_q[wr_ch].key_on <= wr.data[4];
					state_q[wr_ch].sus_on <= wr.data[5];
				end
				opll_pkg::addr_instr[7:4]:
				begin
					state_q[wr_ch].instrument <= wr.data[7:4];
					state_q[wr_ch].volume <= wr.data[3:0];
				end
				default:
				begin
				end
			endcase
		end
	end

	assign ch_state = (ch_sel < 4'(opll_pkg::num_channels)) ? state_q[ch_sel] : '0;

endmodule

`default_nettype wire

// ==== logic/bus_decoder.sv ====
`default_nettype none

module bus_decoder
(
	input wire logic MCLK,
	input wire logic rst_n,
	input wire logic cs,
	input wire logic we,
	input wire logic a0,
	input wire logic [7:0] data,
	output opll_pkg::host_write_t wr
);

	logic [7:0] addr_q;
	logic wr_valid;
	logic [7:0] wr_addr;
	logic [7:0] wr_data;

	always_ff @(posedge MCLK or negedge rst_n)
	begin
		if (!rst_n)
		begin
			addr_q <= '0;
			wr_valid <= 1'b0;
		end
		else
		begin
			wr_valid <= cs & we & a0;
			// address phase
			if (cs && we && !a0)
				addr_q <= data;
		end
	end

	// data phase, address stays for further writes
	always_ff @(posedge MCLK)
	begin
		if (cs && we && a0)
		begin
			wr_addr <= addr_q;
			wr_data <= data;
		end
	end

	assign wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

// ==== common/opll_pkg.sv ====
`default_nettype none

package opll_pkg;

	localparam int num_channels = 9;
	localparam int num_slots = 18;
	localparam int rhythm_first_ch = 6;

	// register address map
	localparam logic [7:0] addr_rhythm = 8'h0e;
	localparam logic [7:0] addr_fnum_lo = 8'h10;
	localparam logic [7:0] addr_fnum_hi = 8'h20;
	localparam logic [7:0] addr_instr = 8'h30;

	typedef struct packed {
		logic valid;
		logic [7:0] addr;
		logic [7:0] data;
	} host_write_t;

	typedef struct packed {
		logic [8:0] fnum;
		logic [2:0] block;
		logic key_on;
		logic sus_on;
		logic [3:0] instrument;
		logic [3:0] volume;
	} channel_state_t;

	typedef struct packed {
		logic am;
		logic vib;
		logic eg_type;
		logic ksr;
		logic [3:0] multi;
		logic [1:0] ksl;
		logic [5:0] tl;
		logic wf;
		logic [2:0] feedback;
		logic [3:0] ar;
		logic [3:0] dr;
		logic [3:0] sl;
		logic [3:0] rr;
	} op_patch_t;

	typedef struct packed {
		op_patch_t modulator;
		op_patch_t carrier;
	} custom_patch_t;

	// same bit order as register 0x0e
	typedef struct packed {
		logic enable;
		logic bd;
		logic sd;
		logic tom;
		logic tc;
		logic hh;
	} rhythm_t;

	typedef struct packed {
		logic valid;
		logic [3:0] channel;
		logic is_car;
		channel_state_t ch_state;
		op_patch_t patch;
	} slot_params_t;

	// eight instrument bytes in register order, byte 0 in the top bits
	function automatic op_patch_t unpack_op(logic [63:0] regs, logic is_car);
		logic [7:0] b2;
		logic [7:0] b3;
		logic [7:0] ch_b;
		logic [7:0] ad_b;
		logic [7:0] sr_b;
		op_patch_t p;
		b2 = regs[47:40];
		b3 = regs[39:32];
		ch_b = is_car ? regs[55:48] : regs[63:56];
		ad_b = is_car ? regs[23:16] : regs[31:24];
		sr_b = is_car ? regs[7:0] : regs[15:8];
		p.am = ch_b[7];
		p.vib = ch_b[6];
		p.eg_type = ch_b[5];
		p.ksr = ch_b[4];
		p.multi = ch_b[3:0];
		p.ksl = is_car ? b3[7:6] : b2[7:6];
		// carrier has no tl or feedback
		p.tl = is_car ? 6'd0 : b2[5:0];
		p.wf = is_car ? b3[4] : b3[3];
		p.feedback = is_car ? 3'd0 : b3[2:0];
		p.ar = ad_b[7:4];
		p.dr = ad_b[3:0];
		p.sl = sr_b[7:4];
		p.rr = sr_b[3:0];
		return p;
	endfunction

endpackage

`default_nettype wire
